// File: design/board_pkg.sv
`default_nettype none

package board_pkg;

    // Cell content, also used for the current player and the winner
    typedef enum logic [1:0] {
        cell_empty = 2'b00,
        player_one = 2'b01,
        player_two = 2'b10
    } cell_t;

    localparam int DEF_ROWS    = 8;
    localparam int DEF_COLS    = 8;
    localparam int DEF_WIN_LEN = 4;

    // Cells in a line centered on the last piece
    function automatic int LINE_LEN(input int win_len);
        return 2 * win_len - 1;
    endfunction

    function automatic cell_t other_player(input cell_t p);
        return (p == player_one) ? player_two : player_one;
    endfunction

endpackage

`default_nettype wire

// File: design/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    typedef enum logic [1:0] {
        op_left  = 2'b00,
        op_right = 2'b01,
        op_drop  = 2'b10
    } opcode_t;

    typedef enum logic [1:0] {
        st_idle  = 2'b00,
        st_place = 2'b01,
        st_check = 2'b10,
        st_won   = 2'b11
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: design/board_store.sv
`default_nettype none

module board_store
#(
    parameter int ROWS    = 8,
    parameter int COLS    = 8,
    parameter int WIN_LEN = 4
)
(
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic [$clog2(COLS)-1:0]  col,
    input  wire logic                     write_en,
    input  board_pkg::cell_t              player,
    output logic                          col_full,
    output board_pkg::cell_t [3:0][board_pkg::LINE_LEN(WIN_LEN)-1:0] lines
);

    import board_pkg::*;

    localparam int ROW_W      = $clog2(ROWS);
    localparam int CNT_W      = $clog2(ROWS + 1);
    localparam int LINE_CELLS = LINE_LEN(WIN_LEN);

    // Row and column steps for vertical, horizontal, rising and falling lines
    localparam int DIR_DR [4] = '{1, 0, 1, -1};
    localparam int DIR_DC [4] = '{0, 1, 1, 1};

    cell_t                 board [ROWS][COLS];
    logic [CNT_W-1:0]      fill [COLS];
    logic [ROW_W-1:0]      last_row;
    logic [$clog2(COLS)-1:0] last_col;
    logic [ROW_W-1:0]      drop_row;

    assign drop_row = ROW_W'(fill[col]);
    assign col_full = (fill[col] == CNT_W'(ROWS));

    always_ff @(posedge clk)
    begin
        if (write_en)
        begin
            board[drop_row][col] <= player;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < COLS; i++)
            begin
                fill[i] <= '0;
            end
            last_row <= '0;
            last_col <= '0;
        end
        else if (write_en)
        begin
            fill[col] <= fill[col] + 1'b1;
            last_row  <= drop_row;
            last_col  <= col;
        end
    end

    // Cells above a column's fill height hold stale data and read as empty
    always_comb
    begin
        int r;
        int c;
        for (int d = 0; d < 4; d++)
        begin
            for (int k = 0; k < LINE_CELLS; k++)
            begin
                r = int'(last_row) + DIR_DR[d] * (k - (WIN_LEN - 1));
                c = int'(last_col) + DIR_DC[d] * (k - (WIN_LEN - 1));
                lines[d][k] = cell_empty;
                if (r >= 0 && r < ROWS && c >= 0 && c < COLS)
                begin
                    if (r < int'(fill[c]))
                    begin
                        lines[d][k] = board[r][c];
                    end
                end
            end
        end
    end

    // The controller must sample col_full before it writes
    write_not_full: assert property (
        @(posedge clk) disable iff (!rst_n) write_en |-> !col_full
    );

endmodule

`default_nettype wire

// File: design/line_checker.sv
`default_nettype none

module line_checker
#(
    parameter int WIN_LEN = 4
)
(
    input  board_pkg::cell_t [board_pkg::LINE_LEN(WIN_LEN)-1:0] line,
    input  board_pkg::cell_t                                     player,
    output logic                                                 hit
);

    import board_pkg::*;

    localparam int LINE_CELLS = LINE_LEN(WIN_LEN);

    // Every window of WIN_LEN cells that fits in the line
    always_comb
    begin
        logic run;
        hit = 1'b0;
        for (int s = 0; s + WIN_LEN <= LINE_CELLS; s++)
        begin
            run = 1'b1;
            for (int k = 0; k < WIN_LEN; k++)
            begin
                if (line[s + k] != player)
                begin
                    run = 1'b0;
                end
            end
            hit = hit | run;
        end
    end

endmodule

`default_nettype wire

// File: design/game_control.sv
`default_nettype none

module game_control
#(
    parameter int COLS = 8
)
(
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     cmd_valid,
    input  ctrl_pkg::opcode_t             cmd_op,
    output logic                          cmd_ready,
    input  wire logic                     col_full,
    input  wire logic [3:0]               hits,
    output logic [$clog2(COLS)-1:0]       col,
    output logic                          write_en,
    output board_pkg::cell_t              player,
    output logic                          game_over,
    output board_pkg::cell_t              winner
);

    import board_pkg::*;
    import ctrl_pkg::*;

    localparam int COL_W = $clog2(COLS);
    localparam logic [COL_W-1:0] LAST_COL = COL_W'(COLS - 1);

    ctrl_state_t state;
    logic        accept;

    assign cmd_ready = (state == st_idle);
    assign accept    = cmd_valid && cmd_ready;
    assign write_en  = (state == st_place) && !col_full;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= st_idle;
            col       <= '0;
            player    <= player_one;
            game_over <= 1'b0;
            winner    <= cell_empty;
        end
        else
        begin
            case (state)
                st_idle:
                begin
                    if (accept)
                    begin
                        case (cmd_op)
                            op_left:  col <= (col == '0) ? LAST_COL : col - 1'b1;
                            op_right: col <= (col == LAST_COL) ? '0 : col + 1'b1;
                            op_drop:  state <= st_place;
                            // Unused encoding is a no-op
                            default:  col <= col;
                        endcase
                    end
                end
                st_place:
                begin
                    // Full column drops nothing and keeps the turn
                    state <= col_full ? st_idle : st_check;
                end
                st_check:
                begin
                    if (|hits)
                    begin
                        state     <= st_won;
                        game_over <= 1'b1;
                        winner    <= player;
                    end
                    else
                    begin
                        player <= other_player(player);
                        state  <= st_idle;
                    end
                end
                default:
                begin
                    state <= st_won;
                end
            endcase
        end
    end

    // Won state keeps commands out until reset
    won_blocks_cmds: assert property (
        @(posedge clk) disable iff (!rst_n) (state == st_won) |=> !cmd_ready
    );

    // Game stays over until reset
    game_over_sticky: assert property (
        @(posedge clk) disable iff (!rst_n) game_over |=> game_over
    );

endmodule

`default_nettype wire

// File: design/connect_four_top.sv
`default_nettype none

module connect_four_top
#(
    parameter int ROWS    = board_pkg::DEF_ROWS,
    parameter int COLS    = board_pkg::DEF_COLS,
    parameter int WIN_LEN = board_pkg::DEF_WIN_LEN
)
(
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     cmd_valid,
    input  ctrl_pkg::opcode_t             cmd_op,
    output logic                          cmd_ready,
    output logic [$clog2(COLS)-1:0]       cur_col,
    output board_pkg::cell_t              cur_player,
    output logic                          game_over,
    output board_pkg::cell_t              winner
);

    import board_pkg::*;

    logic                                 write_en;
    logic                                 col_full;
    logic [3:0]                           hits;
    cell_t [3:0][LINE_LEN(WIN_LEN)-1:0]   lines;

    board_store #(
        .ROWS    (ROWS),
        .COLS    (COLS),
        .WIN_LEN (WIN_LEN)
    ) u_store (
        .clk      (clk),
        .rst_n    (rst_n),
        .col      (cur_col),
        .write_en (write_en),
        .player   (cur_player),
        .col_full (col_full),
        .lines    (lines)
    );

    // One checker per direction
    for (genvar d = 0; d < 4; d++)
    begin : g_dir
        line_checker #(
            .WIN_LEN (WIN_LEN)
        ) u_check (
            .line   (lines[d]),
            .player (cur_player),
            .hit    (hits[d])
        );
    end

    game_control #(
        .COLS (COLS)
    ) u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_ready (cmd_ready),
        .col_full  (col_full),
        .hits      (hits),
        .col       (cur_col),
        .write_en  (write_en),
        .player    (cur_player),
        .game_over (game_over),
        .winner    (winner)
    );

endmodule

`default_nettype wire

// File: test/clock_gen.sv
`default_nettype none

module clock_gen
#(
    parameter int PERIOD       = 4,
    parameter int RESET_CYCLES = 5
)
(
    input  wire logic reset_req,
    output logic      clk,
    output logic      rst_n
);

    int remaining = RESET_CYCLES;

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // A request restarts the reset window
    always @(posedge clk)
    begin
        if (reset_req)
        begin
            remaining <= RESET_CYCLES;
        end
        else if (remaining > 0)
        begin
            remaining <= remaining - 1;
        end
    end

    assign rst_n = (remaining == 0);

endmodule

`default_nettype wire

// File: test/tb_connect_four.sv
`default_nettype none

module tb_connect_four;

    import board_pkg::*;
    import ctrl_pkg::*;

    localparam int RESET_CYCLES = 5;
    localparam int STALL_CYCLES = 4;
    localparam int DRIVE_DELAY  = 1;

    // Record kinds in the data file
    localparam int REC_TEST  = 0;
    localparam int REC_CMD   = 1;
    localparam int REC_BP    = 2;
    localparam int REC_STALL = 3;

    logic                          clk;
    logic                          rst_n;
    logic                          reset_req;
    logic                          cmd_valid;
    opcode_t                       cmd_op;
    logic                          cmd_ready;
    logic [$clog2(DEF_COLS)-1:0]   cur_col;
    cell_t                         cur_player;
    logic                          game_over;
    cell_t                         winner;

    int      rec_kind[$];
    string   rec_name[$];
    opcode_t rec_op_a[$];
    opcode_t rec_op_b[$];
    int      exp_col[$];
    int      exp_player[$];
    int      exp_over[$];
    int      exp_winner[$];

    int      errors = 0;
    int      checks = 0;
    int      cycles = 0;
    int      cycle_limit = 0;
    int      tests_passed = 0;
    int      tests_failed = 0;
    int      test_start_errors = 0;
    bit      in_test = 1'b0;
    string   test_name;

    clock_gen #(
        .PERIOD       (4),
        .RESET_CYCLES (RESET_CYCLES)
    ) clocks0 (
        .reset_req (reset_req),
        .clk       (clk),
        .rst_n     (rst_n)
    );

    connect_four_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_ready  (cmd_ready),
        .cur_col    (cur_col),
        .cur_player (cur_player),
        .game_over  (game_over),
        .winner     (winner)
    );

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit)
        begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
            $display("Test failed");
            $finish;
        end
    end

    task automatic step();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic check_value(input int actual, input int expected, input string what);
        checks++;
        if (actual != expected)
        begin
            errors++;
            $display("[ERROR] %0t: %s: got %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    function automatic opcode_t to_opcode(input logic [127:0] word);
        if (word == "L")
        begin
            return op_left;
        end
        if (word == "R")
        begin
            return op_right;
        end
        return op_drop;
    endfunction

    task automatic add_record(input int kind, input string name, input opcode_t a,
                              input opcode_t b, input int c, input int p, input int o,
                              input int w);
        rec_kind.push_back(kind);
        rec_name.push_back(name);
        rec_op_a.push_back(a);
        rec_op_b.push_back(b);
        exp_col.push_back(c);
        exp_player.push_back(p);
        exp_over.push_back(o);
        exp_winner.push_back(w);
    endtask

    task automatic load_records();
        int               fd;
        int               n;
        int               c;
        int               p;
        int               o;
        int               w;
        logic [1023:0]    text;
        logic [127:0]     kind;
        logic [127:0]     a;
        logic [127:0]     b;
        fd = $fopen("test/game_input.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the stimulus file test/game_input.txt");
            errors++;
            return;
        end
        while (!$feof(fd))
        begin
            text = '0;
            n = $fgets(text, fd);
            n = $sscanf(text, "%s", kind);
            if (n != 1 || kind == "#")
            begin
                continue;
            end
            if (kind == "test" || kind == "stall")
            begin
                n = $sscanf(text, "%s %s", kind, a);
                add_record((kind == "test") ? REC_TEST : REC_STALL, string'(a),
                           to_opcode(a), op_drop, 0, 0, 0, 0);
            end
            else if (kind == "cmd")
            begin
                n = $sscanf(text, "%s %s %d %d %d %d", kind, a, c, p, o, w);
                add_record(REC_CMD, "", to_opcode(a), op_drop, c, p, o, w);
            end
            else if (kind == "bp")
            begin
                n = $sscanf(text, "%s %s %s %d %d %d %d", kind, a, b, c, p, o, w);
                add_record(REC_BP, "", to_opcode(a), to_opcode(b), c, p, o, w);
            end
            else
            begin
                n = 0;
            end
            if (n < 2)
            begin
                $display("Malformed record in the stimulus file: %0s", string'(text));
                errors++;
            end
        end
        $fclose(fd);
    endtask

    task automatic apply_reset();
        cmd_valid = 1'b0;
        reset_req = 1'b1;
        step();
        reset_req = 1'b0;
        while (!rst_n)
        begin
            step();
        end
    endtask

    task automatic idle_gap();
        int n;
        n = $urandom % 4;
        repeat (n) step();
    endtask

    // Holds the command until it transfers on an edge with cmd_ready high
    task automatic send(input opcode_t op);
        cmd_valid = 1'b1;
        cmd_op    = op;
        while (!cmd_ready)
        begin
            step();
        end
        step();
        cmd_valid = 1'b0;
    endtask

    task automatic wait_settled();
        while (!cmd_ready && !game_over)
        begin
            step();
        end
    endtask

    task automatic check_outputs(input int idx);
        check_value(int'(cur_col), exp_col[idx], "cur_col");
        check_value(int'(cur_player), exp_player[idx], "cur_player");
        check_value(int'(game_over), exp_over[idx], "game_over");
        check_value(int'(winner), exp_winner[idx], "winner");
    endtask

    task automatic present_blocked(input opcode_t op);
        cmd_valid = 1'b1;
        cmd_op    = op;
        repeat (STALL_CYCLES)
        begin
            check_value(int'(cmd_ready), 0, "cmd_ready in won state");
            step();
        end
        cmd_valid = 1'b0;
        check_value(int'(game_over), 1, "game_over after won state");
    endtask

    task automatic finish_test();
        if (in_test)
        begin
            if (errors == test_start_errors)
            begin
                tests_passed++;
                $display("test %s: PASS", test_name);
            end
            else
            begin
                tests_failed++;
                $display("test %s: FAIL (%0d errors)", test_name, errors - test_start_errors);
            end
        end
    endtask

    initial
    begin
        void'($urandom(32'h3931));
        reset_req = 1'b0;
        cmd_valid = 1'b0;
        cmd_op    = op_left;
        load_records();
        cycle_limit = rec_kind.size() * 8 + RESET_CYCLES;
        while (rst_n !== 1'b1)
        begin
            step();
        end
        for (int idx = 0; idx < rec_kind.size(); idx++)
        begin
            case (rec_kind[idx])
                REC_TEST:
                begin
                    finish_test();
                    in_test           = 1'b1;
                    test_name         = rec_name[idx];
                    test_start_errors = errors;
                    apply_reset();
                end
                REC_CMD:
                begin
                    idle_gap();
                    send(rec_op_a[idx]);
                    wait_settled();
                    check_outputs(idx);
                end
                REC_BP:
                begin
                    idle_gap();
                    send(rec_op_a[idx]);
                    check_value(int'(cmd_ready), 0, "cmd_ready right after drop");
                    send(rec_op_b[idx]);
                    wait_settled();
                    check_outputs(idx);
                end
                default:
                begin
                    idle_gap();
                    present_blocked(rec_op_a[idx]);
                end
            endcase
        end
        finish_test();
        $display("%0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
                 tests_passed + tests_failed, tests_passed, tests_failed, checks, errors);
        if (errors == 0)
        begin
            $display("Test completed successfully");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/game_input.txt
# test <name> | cmd <op> <col> <player> <over> <winner> | stall <op>
# bp <drop> <op> <col> <player> <over> <winner>  second op waits behind the drop
test cursor
cmd R 1 1 0 0
cmd R 2 1 0 0
cmd L 1 1 0 0
cmd L 0 1 0 0
cmd L 7 1 0 0
cmd R 0 1 0 0
test full_column
cmd D 0 2 0 0
cmd D 0 1 0 0
cmd D 0 2 0 0
cmd D 0 1 0 0
cmd D 0 2 0 0
cmd D 0 1 0 0
cmd D 0 2 0 0
cmd D 0 1 0 0
cmd D 0 1 0 0
test vertical
bp D R 1 2 0 0
bp D L 0 1 0 0
bp D R 1 2 0 0
bp D L 0 1 0 0
bp D R 1 2 0 0
bp D L 0 1 0 0
cmd D 0 1 1 1
stall D
test horizontal
cmd D 0 2 0 0
bp D R 1 1 0 0
cmd D 1 2 0 0
bp D R 2 1 0 0
cmd D 2 2 0 0
bp D R 3 1 0 0
cmd D 3 1 1 1
stall R
test rising
cmd R 1 1 0 0
bp D L 0 2 0 0
bp D R 1 1 0 0
cmd R 2 1 0 0
bp D L 1 2 0 0
bp D R 2 1 0 0
cmd R 3 1 0 0
cmd D 3 2 0 0
cmd D 3 1 0 0
cmd D 3 2 0 0
bp D L 2 1 0 0
cmd D 2 2 0 0
cmd D 2 2 1 2
stall D
test falling
cmd L 7 1 0 0
cmd L 6 1 0 0
bp D R 7 2 0 0
bp D L 6 1 0 0
cmd L 5 1 0 0
bp D R 6 2 0 0
bp D L 5 1 0 0
cmd L 4 1 0 0
cmd D 4 2 0 0
cmd D 4 1 0 0
cmd D 4 2 0 0
bp D R 5 1 0 0
cmd D 5 2 0 0
cmd D 5 2 1 2
stall L

// File: filelist.f
design/board_pkg.sv
design/ctrl_pkg.sv
design/board_store.sv
design/line_checker.sv
design/game_control.sv
design/connect_four_top.sv
test/clock_gen.sv
test/tb_connect_four.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module tb_connect_four \
    -f filelist.f --Mdir obj_dir -o sim_bin
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_bin > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$log"; then
    exit 1
fi
if ! grep -q "Test completed successfully" "$log"; then
    echo "No result found in $log"
    exit 1
fi
exit 0
